// File: hdl/cache_axi_pkg.sv
/*
  Shared sizes and AXI field values for the cache write path.
  NUM_CACHE must equal 2**CACHE_ID_W, and the tag FIFO depth should be a
  power of two. The AXI id is fixed at zero, and one beat is 8 bytes.
*/
package cache_axi_pkg;

  // caches and DMA words
  localparam int NUM_CACHE   = 2;
  localparam int CACHE_ID_W  = 1;
  localparam int ADDR_W      = 32;
  localparam int DATA_W      = 32;
  localparam int STRB_W      = DATA_W / 8;
  localparam int BLOCK_WORDS = 8;

  // AXI beat shape
  localparam int AXI_ID_W    = 1;
  localparam int AXI_DATA_W  = 64;
  localparam int AXI_STRB_W  = AXI_DATA_W / 8;
  localparam int PACK_RATIO  = AXI_DATA_W / DATA_W;
  localparam int BURST_LEN   = 4;

  localparam int TAG_FIFO_DEPTH = 4;

  // counter and pointer widths
  localparam int WORD_CNT_W  = $clog2(BLOCK_WORDS);
  localparam int BURST_CNT_W = $clog2(BURST_LEN);
  localparam int TAG_PTR_W   = $clog2(TAG_FIFO_DEPTH);
  localparam int TAG_CNT_W   = $clog2(TAG_FIFO_DEPTH + 1);

  // constant AW fields
  localparam logic [7:0] AW_LEN_VAL    = 8'(BURST_LEN - 1);
  localparam logic [2:0] AW_SIZE_VAL   = 3'd3;
  localparam logic [1:0] AW_BURST_INCR = 2'b01;
  // device, non-bufferable
  localparam logic [3:0] AW_CACHE_VAL  = 4'b0000;
  // data, secure, unprivileged
  localparam logic [2:0] AW_PROT_VAL   = 3'b000;

  // one entry per accepted address, drained in order
  typedef struct packed {
    logic [CACHE_ID_W-1:0]  cache_id;
    logic [BLOCK_WORDS-1:0] mask;
  } tag_entry_t;

  typedef enum logic {
    ST_IDLE,
    ST_STREAM
  } ctrl_state_t;

endpackage

// File: hdl/tag_fifo.sv
/*
  Tag FIFO between the address and data channels.
  Push while full or pop while empty is illegal and is not guarded here.
  A push shows up on valid_o in the next cycle.
*/
`timescale 1ns/10ps

module tag_fifo (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      push_i,
  input  cache_axi_pkg::tag_entry_t entry_i,
  output logic                      full_o,
  output logic                      valid_o,
  input  logic                      pop_i,
  output cache_axi_pkg::tag_entry_t entry_o
);
  import cache_axi_pkg::*;

  tag_entry_t           mem_r [TAG_FIFO_DEPTH];
  logic [TAG_PTR_W-1:0] wr_ptr_r;
  logic [TAG_PTR_W-1:0] rd_ptr_r;
  logic [TAG_CNT_W-1:0] count_r;

  function automatic logic [TAG_PTR_W-1:0] next_ptr(input logic [TAG_PTR_W-1:0] ptr);
    if (ptr == TAG_PTR_W'(TAG_FIFO_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full_o  = (count_r == TAG_CNT_W'(TAG_FIFO_DEPTH));
  assign valid_o = (count_r != '0);
  assign entry_o = mem_r[rd_ptr_r];

  // storage
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_r[wr_ptr_r] <= entry_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_r <= next_ptr(wr_ptr_r);
      end
      if (pop_i) begin
        rd_ptr_r <= next_ptr(rd_ptr_r);
      end
      // occupancy holds on simultaneous push and pop
      case ({push_i, pop_i})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;
      endcase
    end
  end

endmodule

// File: hdl/word_packer.sv
/*
  Serial-in parallel-out packer for PACK_RATIO elements of elem_t.
  Element 0 lands in the low slot. The full beat is held until yumi_i,
  and no element is taken in the cycle the beat drains.
*/
`timescale 1ns/10ps

module word_packer #(
  parameter type elem_t = logic [31:0]
) (
  input  logic                                    clk_i,
  input  logic                                    reset_i,
  input  logic                                    valid_i,
  input  elem_t                                   elem_i,
  output logic                                    ready_o,
  output logic                                    valid_o,
  output elem_t [cache_axi_pkg::PACK_RATIO-1:0]   beat_o,
  input  logic                                    yumi_i
);
  import cache_axi_pkg::*;

  localparam int FILL_W = $clog2(PACK_RATIO + 1);

  elem_t [PACK_RATIO-1:0] beat_r;
  logic  [FILL_W-1:0]     fill_r;
  logic                   full;
  logic                   accept;

  assign full    = (fill_r == FILL_W'(PACK_RATIO));
  assign ready_o = ~full;
  assign valid_o = full;
  assign beat_o  = beat_r;
  assign accept  = valid_i & ~full;

  // new element enters at the top and moves down
  always_ff @(posedge clk_i) begin
    if (accept) begin
      for (int i = 0; i < PACK_RATIO - 1; i++) begin
        beat_r[i] <= beat_r[i+1];
      end
      beat_r[PACK_RATIO-1] <= elem_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      fill_r <= '0;
    end else if (full && yumi_i) begin
      fill_r <= '0;
    end else if (accept) begin
      fill_r <= fill_r + 1'b1;
    end
  end

endmodule

// File: hdl/beat_counter.sv
/*
  Up-counter that wraps to zero after MAX_VAL.
  The caller owns the terminal compare; there is no clear input.
*/
`timescale 1ns/10ps

module beat_counter #(
  parameter int MAX_VAL = 3
) (
  input  logic                           clk_i,
  input  logic                           reset_i,
  input  logic                           up_i,
  output logic [$clog2(MAX_VAL+1)-1:0]   count_o
);

  localparam int CNT_W = $clog2(MAX_VAL + 1);

  logic [CNT_W-1:0] count_r;

  assign count_o = count_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count_r <= '0;
    end else if (up_i) begin
      // wrap on the terminal value
      if (count_r == CNT_W'(MAX_VAL)) begin
        count_r <= '0;
      end else begin
        count_r <= count_r + 1'b1;
      end
    end
  end

endmodule

// File: hdl/write_data_ctrl.sv
/*
  Drains one cache block per tag entry into the packers.
  An entry takes one idle cycle to latch, then BLOCK_WORDS word pops.
  Only the cache named by the latched entry gets a DMA yumi.
*/
`timescale 1ns/10ps

module write_data_ctrl (
  input  logic                                                          clk_i,
  input  logic                                                          reset_i,
  input  logic                                                          tag_valid_i,
  input  cache_axi_pkg::tag_entry_t                                     tag_entry_i,
  output logic                                                          tag_pop_o,
  input  logic [cache_axi_pkg::NUM_CACHE-1:0]                           dma_data_v_i,
  input  logic [cache_axi_pkg::NUM_CACHE-1:0][cache_axi_pkg::DATA_W-1:0] dma_data_i,
  output logic [cache_axi_pkg::NUM_CACHE-1:0]                           dma_data_yumi_o,
  input  logic                                                          pack_ready_i,
  output logic                                                          pack_valid_o,
  output logic [cache_axi_pkg::DATA_W-1:0]                              pack_data_o,
  output logic [cache_axi_pkg::STRB_W-1:0]                              pack_strb_o
);
  import cache_axi_pkg::*;

  ctrl_state_t           state_r;
  tag_entry_t            entry_r;
  logic [WORD_CNT_W-1:0] word_count;
  logic [NUM_CACHE-1:0]  cache_sel;
  logic                  streaming;
  logic                  word_pop;
  logic                  last_word;

  assign streaming = (state_r == ST_STREAM);
  assign cache_sel = NUM_CACHE'(1) << entry_r.cache_id;

  // selected cache feeds the packers
  assign pack_valid_o    = streaming & dma_data_v_i[entry_r.cache_id];
  assign word_pop        = pack_valid_o & pack_ready_i;
  assign dma_data_yumi_o = cache_sel & {NUM_CACHE{word_pop}};
  assign pack_data_o     = dma_data_i[entry_r.cache_id];

  // one mask bit covers the four bytes of a word
  assign pack_strb_o = {STRB_W{entry_r.mask[word_count]}};

  assign last_word = (word_count == WORD_CNT_W'(BLOCK_WORDS - 1));
  assign tag_pop_o = word_pop & last_word;

  beat_counter #(
    .MAX_VAL(BLOCK_WORDS - 1)
  ) word_counter (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .up_i   (word_pop),
    .count_o(word_count)
  );

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= ST_IDLE;
    end else begin
      case (state_r)
        ST_IDLE: begin
          if (tag_valid_i) begin
            state_r <= ST_STREAM;
          end
        end
        ST_STREAM: begin
          // last pop retires the entry
          if (tag_pop_o) begin
            state_r <= ST_IDLE;
          end
        end
        default: state_r <= ST_IDLE;
      endcase
    end
  end

  // head entry stays in the FIFO until its last word
  always_ff @(posedge clk_i) begin
    if (state_r == ST_IDLE && tag_valid_i) begin
      entry_r <= tag_entry_i;
    end
  end

endmodule

// File: hdl/cache_axi_tx.sv
/*
  Write path from blocking caches to one AXI4 write port.
  Requests must hold steady until yumi_o. Data leaves in address order.
  Read channels are absent, awid is zero and write responses are dropped.
  Up to TAG_FIFO_DEPTH addresses may run ahead of their data.
*/
`timescale 1ns/10ps

module cache_axi_tx (
  input  logic                                                           clk_i,
  input  logic                                                           reset_i,
  input  logic                                                           v_i,
  output logic                                                           yumi_o,
  input  logic [cache_axi_pkg::CACHE_ID_W-1:0]                           cache_id_i,
  input  logic [cache_axi_pkg::ADDR_W-1:0]                               addr_i,
  input  logic [cache_axi_pkg::BLOCK_WORDS-1:0]                          mask_i,
  input  logic                                                           fence_i,
  input  logic [cache_axi_pkg::NUM_CACHE-1:0][cache_axi_pkg::DATA_W-1:0] dma_data_i,
  input  logic [cache_axi_pkg::NUM_CACHE-1:0]                            dma_data_v_i,
  output logic [cache_axi_pkg::NUM_CACHE-1:0]                            dma_data_yumi_o,
  output logic [cache_axi_pkg::AXI_ID_W-1:0]                             awid_o,
  output logic [cache_axi_pkg::ADDR_W-1:0]                               awaddr_o,
  output logic [cache_axi_pkg::CACHE_ID_W-1:0]                           awcache_id_o,
  output logic [7:0]                                                     awlen_o,
  output logic [2:0]                                                     awsize_o,
  output logic [1:0]                                                     awburst_o,
  output logic [3:0]                                                     awcache_o,
  output logic [2:0]                                                     awprot_o,
  output logic                                                           awlock_o,
  output logic                                                           awvalid_o,
  input  logic                                                           awready_i,
  output logic [cache_axi_pkg::AXI_DATA_W-1:0]                           wdata_o,
  output logic [cache_axi_pkg::AXI_STRB_W-1:0]                           wstrb_o,
  output logic                                                           wlast_o,
  output logic                                                           wvalid_o,
  input  logic                                                           wready_i,
  input  logic [cache_axi_pkg::AXI_ID_W-1:0]                             bid_i,
  input  logic [1:0]                                                     bresp_i,
  input  logic                                                           bvalid_i,
  output logic                                                           bready_o
);
  import cache_axi_pkg::*;

  logic                                tag_full;
  logic                                tag_valid;
  logic                                tag_pop;
  tag_entry_t                          tag_push_entry;
  tag_entry_t                          tag_head;
  logic                                aw_fire;
  logic                                w_fire;
  logic                                pack_valid;
  logic                                pack_ready;
  logic [DATA_W-1:0]                   pack_data;
  logic [STRB_W-1:0]                   pack_strb;
  logic [PACK_RATIO-1:0][DATA_W-1:0]   data_beat;
  logic [PACK_RATIO-1:0][STRB_W-1:0]   strb_beat;
  logic [BURST_CNT_W-1:0]              burst_count;

  // address channel, held back by a full FIFO or a fence
  assign awvalid_o = v_i & ~tag_full & ~fence_i;
  assign aw_fire   = awvalid_o & awready_i;
  assign yumi_o    = aw_fire;

  assign awid_o       = '0;
  assign awaddr_o     = addr_i;
  assign awcache_id_o = cache_id_i;
  assign awlen_o      = AW_LEN_VAL;
  assign awsize_o     = AW_SIZE_VAL;
  assign awburst_o    = AW_BURST_INCR;
  assign awcache_o    = AW_CACHE_VAL;
  assign awprot_o     = AW_PROT_VAL;
  assign awlock_o     = 1'b0;

  assign tag_push_entry.cache_id = cache_id_i;
  assign tag_push_entry.mask     = mask_i;

  tag_fifo tag_fifo_inst (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .push_i (aw_fire),
    .entry_i(tag_push_entry),
    .full_o (tag_full),
    .valid_o(tag_valid),
    .pop_i  (tag_pop),
    .entry_o(tag_head)
  );

  write_data_ctrl write_data_ctrl_inst (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .tag_valid_i    (tag_valid),
    .tag_entry_i    (tag_head),
    .tag_pop_o      (tag_pop),
    .dma_data_v_i   (dma_data_v_i),
    .dma_data_i     (dma_data_i),
    .dma_data_yumi_o(dma_data_yumi_o),
    .pack_ready_i   (pack_ready),
    .pack_valid_o   (pack_valid),
    .pack_data_o    (pack_data),
    .pack_strb_o    (pack_strb)
  );

  word_packer #(
    .elem_t(logic [DATA_W-1:0])
  ) data_packer (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .valid_i(pack_valid),
    .elem_i (pack_data),
    .ready_o(pack_ready),
    .valid_o(wvalid_o),
    .beat_o (data_beat),
    .yumi_i (w_fire)
  );

  // fills in lockstep with the data packer
  word_packer #(
    .elem_t(logic [STRB_W-1:0])
  ) strb_packer (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .valid_i(pack_valid),
    .elem_i (pack_strb),
    .ready_o(),
    .valid_o(),
    .beat_o (strb_beat),
    .yumi_i (w_fire)
  );

  assign wdata_o = data_beat;
  assign wstrb_o = strb_beat;
  assign w_fire  = wvalid_o & wready_i;

  beat_counter #(
    .MAX_VAL(BURST_LEN - 1)
  ) burst_counter (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .up_i   (w_fire),
    .count_o(burst_count)
  );

  assign wlast_o = wvalid_o & (burst_count == BURST_CNT_W'(BURST_LEN - 1));

  // responses are accepted and ignored, so bid, bresp and bvalid go nowhere
  assign bready_o = 1'b1;

endmodule

// File: test/cache_axi_tx_chk.sv
/*
  Protocol checker bound into the cache_axi_tx top level.
  Failures raise $error and bump error_count, which the testbench reads.
  All checks are held off during reset.
*/
`timescale 1ns/10ps

module cache_axi_tx_chk (
  input logic                                clk_i,
  input logic                                reset_i,
  input logic                                fence_i,
  input logic                                awvalid_o,
  input logic                                wvalid_o,
  input logic                                wready_i,
  input logic                                wlast_o,
  input logic [cache_axi_pkg::AXI_DATA_W-1:0] wdata_o,
  input logic [cache_axi_pkg::AXI_STRB_W-1:0] wstrb_o,
  input logic [cache_axi_pkg::NUM_CACHE-1:0]  dma_data_yumi_o
);

  int error_count = 0;

  wlast_needs_wvalid: assert property (@(posedge clk_i) disable iff (reset_i)
    wlast_o |-> wvalid_o)
    else begin
      error_count++;
      $error("wlast_o high without wvalid_o");
    end

  // only the owning cache may be popped
  dma_yumi_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(dma_data_yumi_o))
    else begin
      error_count++;
      $error("more than one dma_data_yumi_o bit high");
    end

  w_beat_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    (wvalid_o && !wready_i) |=> (wvalid_o && $stable(wdata_o) && $stable(wstrb_o)))
    else begin
      error_count++;
      $error("W beat changed or dropped while stalled");
    end

  fence_blocks_aw: assert property (@(posedge clk_i) disable iff (reset_i)
    fence_i |-> !awvalid_o)
    else begin
      error_count++;
      $error("awvalid_o high while fence_i is held");
    end

endmodule

// File: test/cache_axi_tx_tb.sv
/*
  Testbench for the cache to AXI write path.
  Rows are issued back to back in table order. A cache presents DMA words
  only for requests whose address was already accepted. Stalls and DMA
  valid drops come from one fixed seed.
*/
`timescale 1ns/10ps

module cache_axi_tx_tb;
  import cache_axi_pkg::*;

  localparam int NUM_ROWS       = 8;
  localparam int TIMEOUT_CYCLES = 400 * NUM_ROWS;

  // stall bit 0 randomizes awready, bit 1 randomizes wready
  typedef struct {
    int                     cache_id;
    logic [ADDR_W-1:0]      addr;
    logic [BLOCK_WORDS-1:0] mask;
    int                     fence;
    logic [1:0]             stall;
  } row_t;

  logic                                clk_i;
  logic                                reset_i;
  logic                                v_i;
  logic                                yumi_o;
  logic [CACHE_ID_W-1:0]               cache_id_i;
  logic [ADDR_W-1:0]                   addr_i;
  logic [BLOCK_WORDS-1:0]              mask_i;
  logic                                fence_i;
  logic [NUM_CACHE-1:0][DATA_W-1:0]    dma_data_i;
  logic [NUM_CACHE-1:0]                dma_data_v_i;
  logic [NUM_CACHE-1:0]                dma_data_yumi_o;
  logic [AXI_ID_W-1:0]                 awid_o;
  logic [ADDR_W-1:0]                   awaddr_o;
  logic [CACHE_ID_W-1:0]               awcache_id_o;
  logic [7:0]                          awlen_o;
  logic [2:0]                          awsize_o;
  logic [1:0]                          awburst_o;
  logic [3:0]                          awcache_o;
  logic [2:0]                          awprot_o;
  logic                                awlock_o;
  logic                                awvalid_o;
  logic                                awready_i;
  logic [AXI_DATA_W-1:0]               wdata_o;
  logic [AXI_STRB_W-1:0]               wstrb_o;
  logic                                wlast_o;
  logic                                wvalid_o;
  logic                                wready_i;
  logic [AXI_ID_W-1:0]                 bid_i;
  logic [1:0]                          bresp_i;
  logic                                bvalid_i;
  logic                                bready_o;

  row_t                   rows [NUM_ROWS];
  int                     exp_aw_row [$];
  logic [AXI_DATA_W-1:0]  exp_wdata [$];
  logic [AXI_STRB_W-1:0]  exp_wstrb [$];
  int                     next_row [NUM_CACHE];
  int                     dma_k [NUM_CACHE];
  int                     aw_count;
  int                     w_count;
  int                     drain_row;
  int                     drain_k;
  int                     errors;
  int                     cycles;
  int                     total;
  integer                 seed;
  logic [1:0]             cur_stall;
  logic [1:0]             stall_now;

  cache_axi_tx cache_axi_tx_inst (.*);

  bind cache_axi_tx cache_axi_tx_chk chk_inst (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .fence_i        (fence_i),
    .awvalid_o      (awvalid_o),
    .wvalid_o       (wvalid_o),
    .wready_i       (wready_i),
    .wlast_o        (wlast_o),
    .wdata_o        (wdata_o),
    .wstrb_o        (wstrb_o),
    .dma_data_yumi_o(dma_data_yumi_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // word k of request n from cache c
  function automatic logic [DATA_W-1:0] word_value(input int c, input int n, input int k);
    return {8'(c + 1), 8'(n), 8'hA5, 8'(k)};
  endfunction

  function automatic int find_row(input int c, input int from);
    for (int n = from; n < NUM_ROWS; n++) begin
      if (rows[n].cache_id == c) begin
        return n;
      end
    end
    return NUM_ROWS;
  endfunction

  task automatic report_error(input string msg);
    errors++;
    $display("Error at %0t: %s", $time, msg);
  endtask

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] got);
    assert (got === exp) else begin
      errors++;
      $display("Fail %0t %s exp %h got %h", $time, name, exp, got);
    end
  endtask

  task automatic build_expected();
    logic [AXI_DATA_W-1:0] data;
    logic [AXI_STRB_W-1:0] strb;
    for (int n = 0; n < NUM_ROWS; n++) begin
      exp_aw_row.push_back(n);
      for (int j = 0; j < BURST_LEN; j++) begin
        data = {word_value(rows[n].cache_id, n, 2 * j + 1),
                word_value(rows[n].cache_id, n, 2 * j)};
        // each mask bit covers one 4-byte group
        for (int b = 0; b < AXI_STRB_W; b++) begin
          strb[b] = rows[n].mask[2 * j + b / STRB_W];
        end
        exp_wdata.push_back(data);
        exp_wstrb.push_back(strb);
      end
    end
  endtask

  task automatic send_request(input int n);
    cache_id_i = CACHE_ID_W'(rows[n].cache_id);
    addr_i     = rows[n].addr;
    mask_i     = rows[n].mask;
    cur_stall  = rows[n].stall;
    v_i        = 1'b1;
    fence_i    = (rows[n].fence > 0);
    for (int i = 0; i < rows[n].fence; i++) begin
      @(negedge clk_i);
      assert (yumi_o === 1'b0) else report_error("request accepted while fenced");
      @(posedge clk_i);
      #1;
    end
    fence_i = 1'b0;
    @(negedge clk_i);
    while (yumi_o !== 1'b1) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #1;
  endtask

  task automatic check_aw();
    int n;
    if (awvalid_o && awready_i) begin
      check_value("yumi_o", 1, yumi_o);
      assert (exp_aw_row.size() > 0) else report_error("AW beat with no request pending");
      if (exp_aw_row.size() > 0) begin
        n = exp_aw_row.pop_front();
        check_value("awaddr_o", rows[n].addr, awaddr_o);
        check_value("awcache_id_o", rows[n].cache_id, awcache_id_o);
        check_value("awlen_o", BURST_LEN - 1, awlen_o);
        check_value("awsize_o", 3, awsize_o);
        check_value("awburst_o", 1, awburst_o);
        check_value("awid_o", 0, awid_o);
        // device non-bufferable, data secure unprivileged, normal access
        check_value("awcache_o", 0, awcache_o);
        check_value("awprot_o", 0, awprot_o);
        check_value("awlock_o", 0, awlock_o);
      end
      aw_count++;
    end else begin
      check_value("yumi_o", 0, yumi_o);
    end
  endtask

  // oldest accepted request owns the DMA pops
  task automatic check_dma();
    int c;
    if (dma_data_yumi_o != '0) begin
      assert (drain_row < aw_count) else report_error("DMA pop with no accepted request");
      if (drain_row < aw_count) begin
        c = rows[drain_row].cache_id;
        check_value("dma_data_yumi_o", 64'(1 << c), 64'(dma_data_yumi_o));
        dma_k[c]++;
        if (dma_k[c] == BLOCK_WORDS) begin
          dma_k[c]    = 0;
          next_row[c] = find_row(c, next_row[c] + 1);
        end
        drain_k++;
        if (drain_k == BLOCK_WORDS) begin
          drain_k = 0;
          drain_row++;
        end
      end
    end
    assert (aw_count - drain_row <= TAG_FIFO_DEPTH) else report_error("too many AW beats ahead");
  endtask

  task automatic check_w();
    if (wvalid_o && wready_i) begin
      assert (exp_wdata.size() > 0) else report_error("W beat with no data expected");
      if (exp_wdata.size() > 0) begin
        check_value("wdata_o", exp_wdata.pop_front(), wdata_o);
        check_value("wstrb_o", exp_wstrb.pop_front(), wstrb_o);
      end
      check_value("wlast_o", (w_count % BURST_LEN) == BURST_LEN - 1, wlast_o);
      check_value("bready_o", 1, bready_o);
      w_count++;
    end
  endtask

  // outputs are settled mid-cycle
  always @(negedge clk_i) begin
    if (!reset_i) begin
      check_aw();
      check_dma();
      check_w();
    end
  end

  // cache DMA ports and AXI slave ready lines
  always @(posedge clk_i) begin
    stall_now = cur_stall;
    #1;
    for (int c = 0; c < NUM_CACHE; c++) begin
      if (next_row[c] < aw_count) begin
        dma_data_v_i[c] = (($random(seed) & 3) != 0);
        dma_data_i[c]   = word_value(c, next_row[c], dma_k[c]);
      end else begin
        dma_data_v_i[c] = 1'b0;
      end
    end
    awready_i = stall_now[0] ? 1'($random(seed)) : 1'b1;
    wready_i  = stall_now[1] ? 1'($random(seed)) : 1'b1;
  end

  initial begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Errors: %0d before the timeout", errors + cache_axi_tx_inst.chk_inst.error_count);
    $display("Some tests failed");
    $finish;
  end

  initial begin
    seed = 32'h9b85156f;
    reset_i = 1'b1;
    v_i = 1'b0;
    cache_id_i = '0;
    addr_i = '0;
    mask_i = '0;
    fence_i = 1'b0;
    dma_data_i = '0;
    dma_data_v_i = '0;
    awready_i = 1'b1;
    wready_i = 1'b1;
    bid_i = '0;
    bresp_i = 2'b00;
    bvalid_i = 1'b0;
    cur_stall = 2'b00;
    stall_now = 2'b00;
    errors = 0;
    aw_count = 0;
    w_count = 0;
    drain_row = 0;
    drain_k = 0;

    // cache id, block address, word mask, fence cycles, stall bits
    rows[0] = '{0, 32'h0000_1000, 8'hFF, 4, 2'b00};
    rows[1] = '{0, 32'h0000_1040, 8'hA5, 0, 2'b00};
    rows[2] = '{1, 32'h0000_2000, 8'hFF, 0, 2'b00};
    rows[3] = '{0, 32'h0000_1080, 8'h3C, 0, 2'b00};
    rows[4] = '{1, 32'h0000_2040, 8'h0F, 6, 2'b00};
    rows[5] = '{0, 32'h0000_10C0, 8'hFF, 0, 2'b11};
    rows[6] = '{1, 32'h0000_2080, 8'h81, 0, 2'b11};
    rows[7] = '{0, 32'h0000_1100, 8'h5A, 3, 2'b10};
    build_expected();
    for (int c = 0; c < NUM_CACHE; c++) begin
      next_row[c] = find_row(c, 0);
      dma_k[c]    = 0;
    end

    repeat (8) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    @(negedge clk_i);
    check_value("awvalid_o", 0, awvalid_o);
    check_value("yumi_o", 0, yumi_o);
    check_value("wvalid_o", 0, wvalid_o);
    check_value("wlast_o", 0, wlast_o);
    check_value("dma_data_yumi_o", 0, dma_data_yumi_o);
    check_value("bready_o", 1, bready_o);
    @(posedge clk_i);
    #1;

    for (int n = 0; n < NUM_ROWS; n++) begin
      send_request(n);
    end
    v_i = 1'b0;
    cur_stall = 2'b00;
    while (exp_wdata.size() != 0) begin
      @(negedge clk_i);
    end
    repeat (4) @(posedge clk_i);
    check_value("aw_count", NUM_ROWS, aw_count);
    check_value("drain_row", NUM_ROWS, drain_row);

    total = errors + cache_axi_tx_inst.chk_inst.error_count;
    $display("Errors: %0d testbench, %0d checker", errors, cache_axi_tx_inst.chk_inst.error_count);
    if (total == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: cache_axi_tx.f
hdl/cache_axi_pkg.sv
hdl/tag_fifo.sv
hdl/word_packer.sv
hdl/beat_counter.sv
hdl/write_data_ctrl.sv
hdl/cache_axi_tx.sv
test/cache_axi_tx_chk.sv
test/cache_axi_tx_tb.sv
